/* build.f */
common/display_pkg.sv
common/pet_pkg.sv
common/sprite_fetch_if.sv
src/anim_sequencer.sv
src/sprite_store.sv
src/frame_compositor.sv
src/pet_display_top.sv
verification/tb_clock_gen.sv
verification/tb_pet_display.sv

/* common/display_pkg.sv */
`default_nettype none

package display_pkg;

    // frame geometry.
    localparam int FRAME_COLS  = 128;
    localparam int FRAME_PAGES = 8;                         // eight pixel rows per byte.
    localparam int FRAME_BYTES = FRAME_COLS * FRAME_PAGES;

    typedef logic [$clog2(FRAME_BYTES)-1:0] byte_index_t;  // column * 8 + page.
    typedef logic [$clog2(FRAME_COLS)-1:0]  column_t;
    typedef logic [$clog2(FRAME_PAGES)-1:0] page_t;
    typedef logic [7:0]                     pixel_t;

    // status bars for happiness, hunger and sleep from left to right.
    localparam int BAR_COUNT                = 3;
    localparam int BAR_COL_FIRST [BAR_COUNT] = '{8, 18, 28};
    localparam int BAR_WIDTH                = 5;            // columns per bar.
    localparam int BAR_ROW_FIRST            = 1;            // top page of a bar.
    localparam int BAR_ROWS                 = 5;

    localparam pixel_t FILL_FULL = 8'hEE;                   // two solid segments.
    localparam pixel_t FILL_HALF = 8'hE0;                   // upper segment only.

    // Page r is full above BAR_TOP - BAR_STEP * r and half above
    // a level that sits half a step lower.
    localparam int BAR_TOP  = 110;
    localparam int BAR_STEP = 20;

endpackage

`default_nettype wire

/* common/pet_pkg.sv */
`default_nettype none

package pet_pkg;

    // one-hot pose codes with idle as all zero.
    typedef logic [3:0] pose_t;

    localparam pose_t POSE_IDLE     = 4'b0000;
    localparam pose_t POSE_SLEEPING = 4'b0001;
    localparam pose_t POSE_EATING   = 4'b0010;
    localparam pose_t POSE_TEACHING = 4'b0100;
    localparam pose_t POSE_DEAD     = 4'b1000;

    localparam int POSE_COUNT = 5;

    // Table order is also the order of the frame slots in sprite memory.
    localparam pose_t POSE_CODE [POSE_COUNT] = '{
        POSE_IDLE,
        POSE_SLEEPING,
        POSE_EATING,
        POSE_TEACHING,
        POSE_DEAD
    };

    localparam int POSE_FRAMES [POSE_COUNT] = '{6, 4, 5, 7, 8};
    localparam int POSE_BASE   [POSE_COUNT] = '{0, 6, 10, 15, 22};   // first slot.
    localparam int TOTAL_FRAMES             = 30;

    typedef logic [2:0] frame_idx_t;                 // up to eight frames.

    // sprite address is slot * 1024 + byte index.
    localparam int SLOT_BITS = $clog2(TOTAL_FRAMES);
    localparam int BYTE_BITS = 10;
    localparam int ADDR_BITS = SLOT_BITS + BYTE_BITS;

    typedef logic [SLOT_BITS-1:0] slot_t;
    typedef logic [ADDR_BITS-1:0] sprite_addr_t;

    typedef logic [7:0] stat_t;                      // 0 to 100.

    typedef struct packed {
        stat_t happiness;
        stat_t hunger;
        stat_t sleep;
    } pet_stats_t;

endpackage

`default_nettype wire

/* common/sprite_fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Index and pose of one pixel fetch go in and the frame is looked up.
// The sprite byte comes back a cycle later.
interface sprite_fetch_if;

    display_pkg::byte_index_t byte_index;
    pet_pkg::pose_t           pose;
    pet_pkg::frame_idx_t      frame;       // current frame of the selected pose.
    display_pkg::pixel_t      pixel;       // registered sprite byte.

    modport sequencer (
        input  pose,
        output frame
    );

    modport memory (
        input  byte_index,
        input  pose,
        input  frame,
        output pixel
    );

    modport compositor (
        input  byte_index,
        input  pixel
    );

endinterface

`default_nettype wire

/* src/anim_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module anim_sequencer #(
    parameter int FRAME_TICK_CYCLES = 2**23
) (
    input  logic              clk,
    input  logic              i_rst_n,
    sprite_fetch_if.sequencer fetch
);

    localparam int CNT_BITS = (FRAME_TICK_CYCLES > 1) ? $clog2(FRAME_TICK_CYCLES) : 1;

    logic [CNT_BITS-1:0] tick_cnt;
    logic                tick;
    pet_pkg::frame_idx_t frame_q [pet_pkg::POSE_COUNT];

    assign tick = (tick_cnt == CNT_BITS'(FRAME_TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;                         // wrap on the tick.
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // All poses step together, so a pose change lands mid-animation.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int p = 0; p < pet_pkg::POSE_COUNT; p++) begin
                frame_q[p] <= '0;
            end
        end else if (tick) begin
            for (int p = 0; p < pet_pkg::POSE_COUNT; p++) begin
                if (frame_q[p] == pet_pkg::frame_idx_t'(pet_pkg::POSE_FRAMES[p] - 1)) begin
                    frame_q[p] <= '0;               // last frame of this pose.
                end else begin
                    frame_q[p] <= frame_q[p] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        fetch.frame = '0;                           // invalid pose reads frame 0.
        for (int p = 0; p < pet_pkg::POSE_COUNT; p++) begin
            if (fetch.pose == pet_pkg::POSE_CODE[p]) begin
                fetch.frame = frame_q[p];
            end
        end
    end

endmodule

`default_nettype wire

/* src/frame_compositor.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_compositor (
    input  logic                 clk,
    input  logic                 i_rst_n,
    sprite_fetch_if.compositor   fetch,
    input  pet_pkg::pet_stats_t  i_stats,
    output display_pkg::pixel_t  o_data
);

    display_pkg::column_t column;
    display_pkg::page_t   page;
    pet_pkg::stat_t       bar_stats [display_pkg::BAR_COUNT];
    pet_pkg::stat_t       hit_stat;
    logic                 col_hit;
    logic                 row_hit;
    logic                 bar_hit;
    int                   full_level;
    int                   half_level;
    display_pkg::pixel_t  bar_byte;
    display_pkg::pixel_t  bar_byte_q;
    logic                 bar_hit_q;

    assign column = display_pkg::column_t'(fetch.byte_index / display_pkg::FRAME_PAGES);
    assign page   = display_pkg::page_t'(fetch.byte_index % display_pkg::FRAME_PAGES);

    assign bar_stats[0] = i_stats.happiness;
    assign bar_stats[1] = i_stats.hunger;
    assign bar_stats[2] = i_stats.sleep;

    assign row_hit = (int'(page) >= display_pkg::BAR_ROW_FIRST)
                  && (int'(page) <  display_pkg::BAR_ROW_FIRST + display_pkg::BAR_ROWS);

    // which bar, if any, owns this column.
    always_comb begin
        col_hit  = 1'b0;
        hit_stat = '0;
        for (int b = 0; b < display_pkg::BAR_COUNT; b++) begin
            if ((int'(column) >= display_pkg::BAR_COL_FIRST[b])
             && (int'(column) <  display_pkg::BAR_COL_FIRST[b] + display_pkg::BAR_WIDTH)) begin
                col_hit  = 1'b1;
                hit_stat = bar_stats[b];
            end
        end
    end

    assign bar_hit = col_hit && row_hit;

    // Page 1 is the top of a bar and needs the highest stat to light.
    assign full_level = display_pkg::BAR_TOP - display_pkg::BAR_STEP * int'(page);
    assign half_level = full_level - display_pkg::BAR_STEP / 2;

    always_comb begin
        if (int'(hit_stat) > full_level) begin
            bar_byte = display_pkg::FILL_FULL;
        end else if (int'(hit_stat) > half_level) begin
            bar_byte = display_pkg::FILL_HALF;
        end else begin
            bar_byte = '0;
        end
    end

    // stage 1 runs alongside the sprite read.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            bar_hit_q  <= 1'b0;
            bar_byte_q <= '0;
        end else begin
            bar_hit_q  <= bar_hit;
            bar_byte_q <= bar_byte;
        end
    end

    // stage 2 puts the bars over the sprite.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else begin
            o_data <= bar_hit_q ? bar_byte_q : fetch.pixel;
        end
    end

endmodule

`default_nettype wire

/* src/pet_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pet_display_top #(
    parameter int FRAME_TICK_CYCLES = 2**23
) (
    input  logic                     clk,
    input  logic                     i_rst_n,

    // display driver side.
    input  display_pkg::byte_index_t i_byte_index,
    input  pet_pkg::pose_t           i_pose,

    // pet state.
    input  pet_pkg::stat_t           i_happiness,
    input  pet_pkg::stat_t           i_hunger,
    input  pet_pkg::stat_t           i_sleep,

    // sprite load port.
    input  logic                     i_load_we,
    input  pet_pkg::sprite_addr_t    i_load_addr,
    input  display_pkg::pixel_t      i_load_data,

    output display_pkg::pixel_t      o_data
);

    pet_pkg::pet_stats_t stats;

    sprite_fetch_if fetch ();

    assign fetch.byte_index = i_byte_index;
    assign fetch.pose       = i_pose;

    assign stats.happiness = i_happiness;
    assign stats.hunger    = i_hunger;
    assign stats.sleep     = i_sleep;

    // one frame index per pose.
    anim_sequencer #(
        .FRAME_TICK_CYCLES (FRAME_TICK_CYCLES)
    ) u_sequencer (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .fetch   (fetch.sequencer)
    );

    // all 30 frames with one byte read per clock.
    sprite_store u_store (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .fetch       (fetch.memory),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data)
    );

    // draws bars over the sprite into o_data.
    frame_compositor u_compositor (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .fetch   (fetch.compositor),
        .i_stats (stats),
        .o_data  (o_data)
    );

endmodule

`default_nettype wire

/* src/sprite_store.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_store (
    input  logic                  clk,
    input  logic                  i_rst_n,
    sprite_fetch_if.memory        fetch,
    input  logic                  i_load_we,
    input  pet_pkg::sprite_addr_t i_load_addr,
    input  display_pkg::pixel_t   i_load_data
);

    localparam int MEM_DEPTH = pet_pkg::TOTAL_FRAMES * display_pkg::FRAME_BYTES;

    display_pkg::pixel_t   mem [MEM_DEPTH];
    pet_pkg::slot_t        slot;
    logic                  pose_valid;
    pet_pkg::sprite_addr_t rd_addr;
    display_pkg::pixel_t   pixel_q;

    // pose to base slot plus the frame offset.
    always_comb begin
        pose_valid = 1'b0;
        slot       = '0;
        for (int p = 0; p < pet_pkg::POSE_COUNT; p++) begin
            if (fetch.pose == pet_pkg::POSE_CODE[p]) begin
                pose_valid = 1'b1;
                slot       = pet_pkg::slot_t'(pet_pkg::POSE_BASE[p])
                           + pet_pkg::slot_t'(fetch.frame);
            end
        end
    end

    assign rd_addr = {slot, fetch.byte_index};      // slot * 1024 + index.

    // load port writes one byte per strobe.
    always_ff @(posedge clk) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_data;
        end
    end

    // A read that hits a byte being loaded in the same cycle
    // still sees the old contents.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pixel_q <= '0;
        end else if (pose_valid) begin
            pixel_q <= mem[rd_addr];
        end else begin
            pixel_q <= '0;                          // unknown pose shows blank.
        end
    end

    assign fetch.pixel = pixel_q;

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release on a falling edge away from the sampling edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/tb_pet_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pet_display;

    localparam int FRAME_TICK     = 4096;
    localparam int MEM_BYTES      = 30 * 1024;
    localparam int NUM_ROWS       = 24;
    localparam int RESET_TIMEOUT  = 20;
    localparam int DRAIN_TIMEOUT  = 8;

    logic                     clk;
    logic                     rst_n;
    display_pkg::byte_index_t byte_index;
    pet_pkg::pose_t           pose;
    pet_pkg::stat_t           happiness;
    pet_pkg::stat_t           hunger;
    pet_pkg::stat_t           sleep;
    logic                     load_we;
    pet_pkg::sprite_addr_t    load_addr;
    display_pkg::pixel_t      load_data;
    display_pkg::pixel_t      data_out;

    display_pkg::pixel_t      mem_model [MEM_BYTES];
    int                       released_edges;
    integer                   seed;

    // expectations in flight with [1] the oldest.
    logic                     pipe_valid [2];
    display_pkg::pixel_t      pipe_exp   [2];
    string                    pipe_name  [2];

    string                    row_name   [NUM_ROWS];
    pet_pkg::pose_t           row_pose   [NUM_ROWS];
    pet_pkg::stat_t           row_happy  [NUM_ROWS];
    pet_pkg::stat_t           row_hunger [NUM_ROWS];
    pet_pkg::stat_t           row_sleep  [NUM_ROWS];
    int                       row_start  [NUM_ROWS];
    int                       row_count  [NUM_ROWS];
    int                       row_idle   [NUM_ROWS];
    int                       row_total;

    tb_clock_gen #(
        .HALF_PERIOD  (20),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    pet_display_top #(
        .FRAME_TICK_CYCLES (FRAME_TICK)
    ) i_dut (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_byte_index (byte_index),
        .i_pose       (pose),
        .i_happiness  (happiness),
        .i_hunger     (hunger),
        .i_sleep      (sleep),
        .i_load_we    (load_we),
        .i_load_addr  (load_addr),
        .i_load_data  (load_data),
        .o_data       (data_out)
    );

    // clock edges seen with reset released.
    always @(posedge clk) begin
        if (rst_n) begin
            released_edges <= released_edges + 1;
        end
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_pixel(input display_pkg::pixel_t expected,
                               input display_pkg::pixel_t actual, input string name);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int pose_number(input pet_pkg::pose_t code);
        case (code)
            4'b0000: return 0;
            4'b0001: return 1;
            4'b0010: return 2;
            4'b0100: return 3;
            4'b1000: return 4;
            default: return -1;                     // not a pose.
        endcase
    endfunction

    function automatic int frame_count(input int p);
        case (p)
            0:       return 6;
            1:       return 4;
            2:       return 5;
            3:       return 7;
            default: return 8;
        endcase
    endfunction

    function automatic int first_slot(input int p);
        case (p)
            0:       return 0;
            1:       return 6;
            2:       return 10;
            3:       return 15;
            default: return 22;
        endcase
    endfunction

    function automatic int bar_of_column(input int col);
        if (col >= 8 && col < 13) return 0;
        if (col >= 18 && col < 23) return 1;
        if (col >= 28 && col < 33) return 2;
        return -1;
    endfunction

    // byte the display should get k edges after reset release.
    function automatic display_pkg::pixel_t expected_byte(
        input display_pkg::byte_index_t idx, input pet_pkg::pose_t code,
        input pet_pkg::stat_t h, input pet_pkg::stat_t hu, input pet_pkg::stat_t s,
        input int k);
        int col;
        int page;
        int bar;
        int level;
        int p;
        int slot;
        col  = int'(idx) / 8;
        page = int'(idx) % 8;
        bar  = bar_of_column(col);
        if (bar >= 0 && page >= 1 && page <= 5) begin
            level = (bar == 0) ? int'(h) : (bar == 1) ? int'(hu) : int'(s);
            if (level > 110 - 20 * page) return 8'hEE;
            if (level > 100 - 20 * page) return 8'hE0;
            return 8'h00;
        end
        p = pose_number(code);
        if (p < 0) return 8'h00;
        slot = first_slot(p) + (k / FRAME_TICK) % frame_count(p);
        return mem_model[slot * 1024 + int'(idx)];
    endfunction

    // one falling edge that retires the oldest expectation.
    task automatic advance();
        @(negedge clk);
        if (pipe_valid[1]) begin
            check_pixel(pipe_exp[1], data_out, pipe_name[1]);
        end
        pipe_valid[1] = pipe_valid[0];
        pipe_exp[1]   = pipe_exp[0];
        pipe_name[1]  = pipe_name[0];
        pipe_valid[0] = 1'b0;
    endtask

    task automatic add_row(input string name, input pet_pkg::pose_t code,
                           input int h, input int hu, input int s,
                           input int start, input int count, input int idle);
        row_name[row_total]   = name;
        row_pose[row_total]   = code;
        row_happy[row_total]  = pet_pkg::stat_t'(h);
        row_hunger[row_total] = pet_pkg::stat_t'(hu);
        row_sleep[row_total]  = pet_pkg::stat_t'(s);
        row_start[row_total]  = start;
        row_count[row_total]  = count;
        row_idle[row_total]   = idle;
        row_total++;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (1) begin
            @(negedge clk);
            check_pixel(8'h00, data_out, "reset");
            if (released_edges > 0) break;
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("reset was never released");
                abort_run();
            end
        end
    endtask

    task automatic load_memory();
        display_pkg::pixel_t value;
        for (int a = 0; a < MEM_BYTES; a++) begin
            advance();
            value        = display_pkg::pixel_t'($random(seed));
            load_we      = 1'b1;
            load_addr    = pet_pkg::sprite_addr_t'(a);
            load_data    = value;
            mem_model[a] = value;
        end
        advance();
        load_we = 1'b0;
    endtask

    task automatic run_row(input int r);
        display_pkg::byte_index_t idx;
        repeat (row_idle[r]) advance();
        for (int i = 0; i < row_count[r]; i++) begin
            advance();
            idx        = display_pkg::byte_index_t'(row_start[r] + i);   // wraps at 1024.
            byte_index = idx;
            pose       = row_pose[r];
            happiness  = row_happy[r];
            hunger     = row_hunger[r];
            sleep      = row_sleep[r];
            pipe_valid[0] = 1'b1;
            pipe_exp[0]   = expected_byte(idx, row_pose[r], row_happy[r], row_hunger[r],
                                          row_sleep[r], released_edges);
            pipe_name[0]  = $sformatf("%s idx %0d", row_name[r], idx);
        end
    endtask

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        while (pipe_valid[0] || pipe_valid[1]) begin
            advance();
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                $display("pipeline did not drain");
                abort_run();
            end
        end
    endtask

    initial begin
        byte_index     = '0;
        pose           = 4'b0000;
        happiness      = '0;
        hunger         = '0;
        sleep          = '0;
        load_we        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        released_edges = 0;
        seed           = 32'hc62c_4108;
        row_total      = 0;
        for (int i = 0; i < 2; i++) begin
            pipe_valid[i] = 1'b0;
            pipe_exp[i]   = '0;
            pipe_name[i]  = "";
        end

        // name, pose, happiness, hunger, sleep, start, count, idle.
        add_row("idle_left",     4'b0000, 50, 50, 50, 0, 64, 0);
        add_row("idle_right",    4'b0000, 50, 50, 50, 264, 760, 0);
        add_row("sleep_left",    4'b0001, 50, 50, 50, 0, 64, 2);
        add_row("eat_right",     4'b0010, 50, 50, 50, 264, 200, 0);
        add_row("teach_right",   4'b0100, 50, 50, 50, 600, 300, 1);
        add_row("dead_left",     4'b1000, 50, 50, 50, 0, 64, 0);
        add_row("bars_a",        4'b0000, 0, 15, 45, 64, 200, 0);
        add_row("bars_b",        4'b0001, 15, 45, 85, 64, 200, 0);
        add_row("bars_c",        4'b0010, 45, 85, 95, 64, 200, 3);
        add_row("bars_d",        4'b0100, 85, 95, 100, 64, 200, 0);
        add_row("bars_e",        4'b1000, 95, 100, 0, 64, 200, 0);
        add_row("bars_f",        4'b0000, 100, 0, 15, 64, 200, 0);
        add_row("idle_later",    4'b0000, 60, 60, 60, 300, 4, 8192);
        add_row("sleep_later",   4'b0001, 60, 60, 60, 300, 4, 4096);
        add_row("eat_later",     4'b0010, 60, 60, 60, 300, 4, 12288);
        add_row("teach_later",   4'b0100, 60, 60, 60, 300, 4, 4096);
        add_row("dead_later",    4'b1000, 60, 60, 60, 300, 4, 4096);
        add_row("idle_wrap",     4'b0000, 30, 70, 90, 0, 7 * FRAME_TICK, 0);
        add_row("sleep_wrap",    4'b0001, 30, 70, 90, 0, 5 * FRAME_TICK, 0);
        add_row("eat_wrap",      4'b0010, 30, 70, 90, 0, 6 * FRAME_TICK, 0);
        add_row("teach_wrap",    4'b0100, 30, 70, 90, 0, 8 * FRAME_TICK, 0);
        add_row("dead_wrap",     4'b1000, 30, 70, 90, 0, 9 * FRAME_TICK, 0);
        add_row("bad_pose_0011", 4'b0011, 100, 45, 85, 0, 1024, 0);
        add_row("bad_pose_1111", 4'b1111, 95, 15, 0, 0, 1024, 2);

        wait_reset_release();
        load_memory();
        for (int r = 0; r < row_total; r++) begin
            run_row(r);
        end
        drain_pipeline();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
